/* hdl/mem_sys_pkg.sv */
package mem_sys_pkg;

  //////////////////////////////////////////////////
  // Line and address geometry

  localparam int LINE_BYTES     = 8;
  localparam int LINE_BITS      = 64;
  localparam int DMEM_ADDR_BITS = 15;

  // Banks are interleaved on one byte-address bit with the line index above it
  localparam int BANK_SEL_BIT   = 3;
  localparam int BANK_LINE_BITS = 11;
  localparam int WORD_LANE_BIT  = 2;

  //////////////////////////////////////////////////
  // Broadcast region and queue depths

  localparam int BC_WORD_ADDR_BITS = 8;
  localparam logic [DMEM_ADDR_BITS-1:0] BC_START_ADDR = 'h7C00;

  localparam int REQ_FIFO_DEPTH  = 4;
  localparam int RESP_FIFO_DEPTH = 8;

  //////////////////////////////////////////////////
  // Types

  typedef logic [DMEM_ADDR_BITS-1:0]    dmem_addr_t;
  typedef logic [LINE_BITS-1:0]         line_data_t;
  typedef logic [LINE_BYTES-1:0]        line_strb_t;
  typedef logic [31:0]                  word_data_t;
  typedef logic [3:0]                   word_strb_t;
  typedef logic [BANK_LINE_BITS-1:0]    bank_line_t;
  typedef logic [BC_WORD_ADDR_BITS-1:0] bc_word_addr_t;

  typedef struct packed {
    dmem_addr_t addr;
    line_strb_t strb;
    line_data_t data;
  } dma_wr_req_t;

  typedef struct packed {
    bc_word_addr_t word_addr;
    word_strb_t    strb;
    word_data_t    data;
  } bc_msg_t;

  // A read is an enabled access with all strobes low
  typedef struct packed {
    logic       en;
    line_strb_t wstrb;
    bank_line_t line;
    line_data_t wdata;
  } bank_port_t;

endpackage

/* hdl/req_fifo.sv */
`timescale 1ns/1ps

module req_fifo #(
  parameter int WIDTH = 64,
  parameter int DEPTH = 4
) (
  input  logic                       clk,
  input  logic                       rst,
  input  logic                       in_valid,
  input  logic [WIDTH-1:0]           in_data,
  output logic                       in_ready,
  output logic                       out_valid,
  output logic [WIDTH-1:0]           out_data,
  input  logic                       out_ready,
  output logic [$clog2(DEPTH+1)-1:0] count
);

  logic [WIDTH-1:0]         mem [DEPTH];
  logic [$clog2(DEPTH)-1:0] wr_ptr;
  logic [$clog2(DEPTH)-1:0] rd_ptr;
  logic                     push;
  logic                     pop;

  function automatic logic [$clog2(DEPTH)-1:0] next_ptr(input logic [$clog2(DEPTH)-1:0] ptr);
    return (ptr == DEPTH - 1) ? '0 : ptr + 1'b1;
  endfunction

  // Ready only looks at occupancy and the head falls through
  assign in_ready  = (count != DEPTH);
  assign out_valid = (count != '0);
  assign out_data  = mem[rd_ptr];

  assign push = in_valid && in_ready;
  assign pop  = out_valid && out_ready;

  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= in_data;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= next_ptr(wr_ptr);
      end
      if (pop) begin
        rd_ptr <= next_ptr(rd_ptr);
      end
      if (push && !pop) begin
        count <= count + 1'b1;
      end else if (pop && !push) begin
        count <= count - 1'b1;
      end
    end
  end

endmodule

/* hdl/bc_msg_unpack.sv */
`timescale 1ns/1ps

module bc_msg_unpack (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    bc_valid,
  input  mem_sys_pkg::bc_msg_t    bc_msg,
  output logic                    port_valid,
  output logic                    port_bank,
  output mem_sys_pkg::bank_port_t port_req
);

  logic                    valid_r;
  mem_sys_pkg::bc_msg_t    msg_r;
  mem_sys_pkg::dmem_addr_t bc_addr;
  mem_sys_pkg::bank_line_t line_rr;
  mem_sys_pkg::line_strb_t strb_rr;
  mem_sys_pkg::line_data_t data_rr;

  // Word index is in 32-bit units counted from the start of the region
  assign bc_addr = mem_sys_pkg::BC_START_ADDR
                   + mem_sys_pkg::dmem_addr_t'({msg_r.word_addr, 2'b00});

  always_ff @(posedge clk) begin
    msg_r <= bc_msg;
    if (rst) begin
      valid_r <= 1'b0;
    end else begin
      valid_r <= bc_valid;
    end
  end

  // Second stage places the word in its lane and picks the bank
  always_ff @(posedge clk) begin
    port_bank <= bc_addr[mem_sys_pkg::BANK_SEL_BIT];
    line_rr   <= bc_addr[mem_sys_pkg::DMEM_ADDR_BITS-1:mem_sys_pkg::BANK_SEL_BIT+1];
    if (bc_addr[mem_sys_pkg::WORD_LANE_BIT]) begin
      strb_rr <= {msg_r.strb, 4'b0000};
      data_rr <= {msg_r.data, 32'h0};
    end else begin
      strb_rr <= {4'b0000, msg_r.strb};
      data_rr <= {32'h0, msg_r.data};
    end
    if (rst) begin
      port_valid <= 1'b0;
    end else begin
      port_valid <= valid_r;
    end
  end

  assign port_req = '{en: port_valid, wstrb: strb_rr, line: line_rr, wdata: data_rr};

endmodule

/* hdl/core_lane_adapter.sv */
`timescale 1ns/1ps

module core_lane_adapter (
  input  logic                          clk,
  input  logic                          rst,
  input  logic                          core_en,
  input  logic                          core_we,
  input  mem_sys_pkg::word_strb_t       core_strb,
  input  mem_sys_pkg::dmem_addr_t       core_addr,
  input  mem_sys_pkg::word_data_t       core_wdata,
  output mem_sys_pkg::bank_port_t [1:0] bank_b,
  input  mem_sys_pkg::line_data_t [1:0] bank_rdata,
  output logic                          core_rd_valid,
  output mem_sys_pkg::word_data_t       core_rd_data
);

  mem_sys_pkg::line_strb_t lane_strb;
  mem_sys_pkg::line_data_t lane_data;
  mem_sys_pkg::line_data_t rd_line;
  logic                    rd_bank_r;
  logic                    rd_lane_r;

  //////////////////////////////////////////////////
  // Request side

  // Bit 2 of the address picks the upper or lower word of the line
  assign lane_strb = core_addr[mem_sys_pkg::WORD_LANE_BIT] ? {core_strb, 4'b0000}
                                                           : {4'b0000, core_strb};
  assign lane_data = core_addr[mem_sys_pkg::WORD_LANE_BIT] ? {core_wdata, 32'h0}
                                                           : {32'h0, core_wdata};

  always_comb begin
    for (int b = 0; b < 2; b++) begin
      bank_b[b].en    = core_en && (core_addr[mem_sys_pkg::BANK_SEL_BIT] == 1'(b));
      bank_b[b].wstrb = core_we ? lane_strb : '0;
      bank_b[b].line  = core_addr[mem_sys_pkg::DMEM_ADDR_BITS-1:mem_sys_pkg::BANK_SEL_BIT+1];
      bank_b[b].wdata = lane_data;
    end
  end

  //////////////////////////////////////////////////
  // Read return

  always_ff @(posedge clk) begin
    rd_bank_r <= core_addr[mem_sys_pkg::BANK_SEL_BIT];
    rd_lane_r <= core_addr[mem_sys_pkg::WORD_LANE_BIT];
    if (rst) begin
      core_rd_valid <= 1'b0;
    end else begin
      core_rd_valid <= core_en && !core_we;
    end
  end

  // Bank output is already registered, so only the lane mux remains
  assign rd_line      = bank_rdata[rd_bank_r];
  assign core_rd_data = rd_lane_r ? rd_line[63:32] : rd_line[31:0];

endmodule

/* hdl/dmem_port_arbiter.sv */
`timescale 1ns/1ps

module dmem_port_arbiter (
  input  logic                          bc_valid,
  input  logic                          bc_bank,
  input  mem_sys_pkg::bank_port_t       bc_req,
  input  logic                          wr_valid,
  input  mem_sys_pkg::dma_wr_req_t      wr_req,
  output logic                          wr_pop,
  input  logic                          rd_valid,
  input  mem_sys_pkg::dmem_addr_t       rd_addr,
  output logic                          rd_pop,
  input  logic                          rd_space,
  output logic                          rd_issue,
  output logic                          rd_bank,
  output mem_sys_pkg::bank_port_t [1:0] bank_a
);

  logic wr_bank;
  logic rd_ok;

  assign wr_bank = wr_req.addr[mem_sys_pkg::BANK_SEL_BIT];
  assign rd_bank = rd_addr[mem_sys_pkg::BANK_SEL_BIT];

  // A read waits until every queued write has landed and the response FIFO has room
  assign rd_ok = rd_valid && !wr_valid && rd_space;

  // Each bank serves broadcast first, then the DMA write and then the DMA read
  always_comb begin
    wr_pop = 1'b0;
    rd_pop = 1'b0;
    for (int b = 0; b < 2; b++) begin
      bank_a[b] = '0;
      if (bc_valid && (bc_bank == 1'(b))) begin
        bank_a[b] = bc_req;
      end else if (wr_valid && (wr_bank == 1'(b))) begin
        bank_a[b].en    = 1'b1;
        bank_a[b].wstrb = wr_req.strb;
        bank_a[b].line  = wr_req.addr[mem_sys_pkg::DMEM_ADDR_BITS-1:mem_sys_pkg::BANK_SEL_BIT+1];
        bank_a[b].wdata = wr_req.data;
        wr_pop          = 1'b1;
      end else if (rd_ok && (rd_bank == 1'(b))) begin
        bank_a[b].en   = 1'b1;
        bank_a[b].line = rd_addr[mem_sys_pkg::DMEM_ADDR_BITS-1:mem_sys_pkg::BANK_SEL_BIT+1];
        rd_pop         = 1'b1;
      end
    end
  end

  assign rd_issue = rd_pop;

endmodule

/* hdl/dmem_bank.sv */
`timescale 1ns/1ps

module dmem_bank (
  input  logic                    clk,
  input  mem_sys_pkg::bank_port_t port_a,
  output mem_sys_pkg::line_data_t rdata_a,
  input  mem_sys_pkg::bank_port_t port_b,
  output mem_sys_pkg::line_data_t rdata_b
);

  mem_sys_pkg::line_data_t mem [2**mem_sys_pkg::BANK_LINE_BITS];

  // Both ports read the old line on the edge that writes it.
  // Same-line writes from both ports in one cycle are not defined
  always_ff @(posedge clk) begin
    if (port_a.en) begin
      for (int i = 0; i < mem_sys_pkg::LINE_BYTES; i++) begin
        if (port_a.wstrb[i]) begin
          mem[port_a.line][8*i +: 8] <= port_a.wdata[8*i +: 8];
        end
      end
      rdata_a <= mem[port_a.line];
    end
    if (port_b.en) begin
      for (int i = 0; i < mem_sys_pkg::LINE_BYTES; i++) begin
        if (port_b.wstrb[i]) begin
          mem[port_b.line][8*i +: 8] <= port_b.wdata[8*i +: 8];
        end
      end
      rdata_b <= mem[port_b.line];
    end
  end

endmodule

/* hdl/dma_resp_path.sv */
`timescale 1ns/1ps

module dma_resp_path (
  input  logic                          clk,
  input  logic                          rst,
  input  logic                          rd_issue,
  input  logic                          rd_bank,
  input  mem_sys_pkg::line_data_t [1:0] bank_rdata,
  output logic                          rd_space,
  output logic                          resp_valid,
  output mem_sys_pkg::line_data_t       resp_data,
  input  logic                          resp_ready
);

  logic                                           issue_r;
  logic                                           bank_r;
  logic [$clog2(mem_sys_pkg::RESP_FIFO_DEPTH+1)-1:0] resp_count;

  // Port A data shows up one cycle after the grant
  always_ff @(posedge clk) begin
    bank_r <= rd_bank;
    if (rst) begin
      issue_r <= 1'b0;
    end else begin
      issue_r <= rd_issue;
    end
  end

  req_fifo #(
    .WIDTH(mem_sys_pkg::LINE_BITS),
    .DEPTH(mem_sys_pkg::RESP_FIFO_DEPTH)
  ) resp_fifo (
    .clk      (clk),
    .rst      (rst),
    .in_valid (issue_r),
    .in_data  (bank_rdata[bank_r]),
    .in_ready (),
    .out_valid(resp_valid),
    .out_data (resp_data),
    .out_ready(resp_ready),
    .count    (resp_count)
  );

  // Two free slots cover the read being pushed and the one granted now
  assign rd_space = (resp_count <= mem_sys_pkg::RESP_FIFO_DEPTH - 2);

endmodule

/* hdl/mem_sys_top.sv */
`timescale 1ns/1ps

module mem_sys_top (
  input  logic                     clk,
  input  logic                     rst,

  input  logic                     dma_wr_valid,
  input  mem_sys_pkg::dma_wr_req_t dma_wr_req,
  output logic                     dma_wr_ready,

  input  logic                     dma_rd_valid,
  input  mem_sys_pkg::dmem_addr_t  dma_rd_addr,
  output logic                     dma_rd_ready,

  output logic                     dma_rd_resp_valid,
  output mem_sys_pkg::line_data_t  dma_rd_resp_data,
  input  logic                     dma_rd_resp_ready,

  input  logic                     core_en,
  input  logic                     core_we,
  input  mem_sys_pkg::word_strb_t  core_strb,
  input  mem_sys_pkg::dmem_addr_t  core_addr,
  input  mem_sys_pkg::word_data_t  core_wdata,
  output logic                     core_rd_valid,
  output mem_sys_pkg::word_data_t  core_rd_data,

  input  logic                     bc_valid,
  input  mem_sys_pkg::bc_msg_t     bc_msg
);

  logic                          wr_head_valid;
  mem_sys_pkg::dma_wr_req_t      wr_head;
  logic                          wr_pop;
  logic                          rd_head_valid;
  mem_sys_pkg::dmem_addr_t       rd_head_addr;
  logic                          rd_pop;
  logic                          bc_port_valid;
  logic                          bc_port_bank;
  mem_sys_pkg::bank_port_t       bc_port_req;
  logic                          rd_space;
  logic                          rd_issue;
  logic                          rd_bank;
  mem_sys_pkg::bank_port_t [1:0] bank_a;
  mem_sys_pkg::bank_port_t [1:0] bank_b;
  mem_sys_pkg::line_data_t [1:0] rdata_a;
  mem_sys_pkg::line_data_t [1:0] rdata_b;

  //////////////////////////////////////////////////
  // DMA request queues

  req_fifo #(
    .WIDTH($bits(mem_sys_pkg::dma_wr_req_t)),
    .DEPTH(mem_sys_pkg::REQ_FIFO_DEPTH)
  ) wr_fifo (
    .clk(clk), .rst(rst),
    .in_valid(dma_wr_valid), .in_data(dma_wr_req), .in_ready(dma_wr_ready),
    .out_valid(wr_head_valid), .out_data(wr_head), .out_ready(wr_pop),
    .count()
  );

  req_fifo #(
    .WIDTH(mem_sys_pkg::DMEM_ADDR_BITS),
    .DEPTH(mem_sys_pkg::REQ_FIFO_DEPTH)
  ) rd_fifo (
    .clk(clk), .rst(rst),
    .in_valid(dma_rd_valid), .in_data(dma_rd_addr), .in_ready(dma_rd_ready),
    .out_valid(rd_head_valid), .out_data(rd_head_addr), .out_ready(rd_pop),
    .count()
  );

  bc_msg_unpack u_bc_unpack (
    .clk(clk), .rst(rst), .bc_valid(bc_valid), .bc_msg(bc_msg),
    .port_valid(bc_port_valid), .port_bank(bc_port_bank), .port_req(bc_port_req)
  );

  core_lane_adapter u_core_adapter (
    .clk(clk), .rst(rst),
    .core_en(core_en), .core_we(core_we), .core_strb(core_strb),
    .core_addr(core_addr), .core_wdata(core_wdata),
    .bank_b(bank_b), .bank_rdata(rdata_b),
    .core_rd_valid(core_rd_valid), .core_rd_data(core_rd_data)
  );

  //////////////////////////////////////////////////
  // Shared port A arbitration and the banks

  dmem_port_arbiter u_arbiter (
    .bc_valid(bc_port_valid), .bc_bank(bc_port_bank), .bc_req(bc_port_req),
    .wr_valid(wr_head_valid), .wr_req(wr_head), .wr_pop(wr_pop),
    .rd_valid(rd_head_valid), .rd_addr(rd_head_addr), .rd_pop(rd_pop),
    .rd_space(rd_space), .rd_issue(rd_issue), .rd_bank(rd_bank),
    .bank_a(bank_a)
  );

  dmem_bank bank0 (
    .clk(clk), .port_a(bank_a[0]), .rdata_a(rdata_a[0]),
    .port_b(bank_b[0]), .rdata_b(rdata_b[0])
  );

  dmem_bank bank1 (
    .clk(clk), .port_a(bank_a[1]), .rdata_a(rdata_a[1]),
    .port_b(bank_b[1]), .rdata_b(rdata_b[1])
  );

  dma_resp_path u_resp_path (
    .clk(clk), .rst(rst),
    .rd_issue(rd_issue), .rd_bank(rd_bank), .bank_rdata(rdata_a),
    .rd_space(rd_space),
    .resp_valid(dma_rd_resp_valid), .resp_data(dma_rd_resp_data),
    .resp_ready(dma_rd_resp_ready)
  );

endmodule

/* verification/mem_sys_assert.sv */
`timescale 1ns/1ps

module mem_sys_assert (
  input logic                                              clk,
  input logic                                              rst,
  input logic                                              resp_valid,
  input logic                                              resp_ready,
  input mem_sys_pkg::line_data_t                           resp_data,
  input logic                                              core_en,
  input logic                                              core_we,
  input logic                                              core_rd_valid,
  input logic                                              resp_push,
  input logic [$clog2(mem_sys_pkg::RESP_FIFO_DEPTH+1)-1:0] resp_count
);

  int unsigned failures;

  // A stalled response keeps both valid and data until the master takes it
  resp_held: assert property (@(posedge clk) disable iff (rst)
    resp_valid && !resp_ready |=> resp_valid && $stable(resp_data))
    else begin
      failures++;
      $error("DMA response dropped or changed while stalled");
    end

  core_rd_follows: assert property (@(posedge clk) disable iff (rst)
    core_en && !core_we |=> core_rd_valid)
    else begin
      failures++;
      $error("core_rd_valid missing one cycle after a core read");
    end

  core_rd_only_after_read: assert property (@(posedge clk) disable iff (rst)
    !(core_en && !core_we) |=> !core_rd_valid)
    else begin
      failures++;
      $error("core_rd_valid raised without a core read");
    end

  // The read window in the arbiter keeps two slots free
  resp_no_overflow: assert property (@(posedge clk) disable iff (rst)
    resp_push |-> resp_count < mem_sys_pkg::RESP_FIFO_DEPTH)
    else begin
      failures++;
      $error("response FIFO pushed while full");
    end

endmodule

bind mem_sys_top mem_sys_assert u_assert (
  .clk          (clk),
  .rst          (rst),
  .resp_valid   (dma_rd_resp_valid),
  .resp_ready   (dma_rd_resp_ready),
  .resp_data    (dma_rd_resp_data),
  .core_en      (core_en),
  .core_we      (core_we),
  .core_rd_valid(core_rd_valid),
  .resp_push    (u_resp_path.issue_r),
  .resp_count   (u_resp_path.resp_count)
);

/* verification/mem_sys_tb.sv */
`timescale 1ns/1ps

module mem_sys_tb;

  localparam int NUM_DMA   = 32;
  localparam int NUM_CORE  = 16;
  localparam int NUM_BURST = 24;

  // About 100 cycles per access covers the slowest read under full back-pressure
  localparam int TIMEOUT_CYCLES = 100 * (2 * NUM_DMA + 2 * NUM_CORE + 4 * NUM_BURST + 8);

  logic                     clk;
  logic                     rst;
  logic                     dma_wr_valid;
  mem_sys_pkg::dma_wr_req_t dma_wr_req;
  logic                     dma_wr_ready;
  logic                     dma_rd_valid;
  mem_sys_pkg::dmem_addr_t  dma_rd_addr;
  logic                     dma_rd_ready;
  logic                     dma_rd_resp_valid;
  mem_sys_pkg::line_data_t  dma_rd_resp_data;
  logic                     dma_rd_resp_ready;
  logic                     core_en;
  logic                     core_we;
  mem_sys_pkg::word_strb_t  core_strb;
  mem_sys_pkg::dmem_addr_t  core_addr;
  mem_sys_pkg::word_data_t  core_wdata;
  logic                     core_rd_valid;
  mem_sys_pkg::word_data_t  core_rd_data;
  logic                     bc_valid;
  mem_sys_pkg::bc_msg_t     bc_msg;

  // Byte-wide image of dmem where unwritten bytes stay X as they do in the banks
  logic [7:0]  model [2**mem_sys_pkg::DMEM_ADDR_BITS];
  logic [63:0] exp_q [$];
  int unsigned dma_lines [$];
  int unsigned core_words [$];
  int unsigned bc_lines [$];
  int          errors;
  int          checks;
  int          cycles;
  bit          resp_random;
  bit          burst_done;

  mem_sys_top dut (
    .clk              (clk),
    .rst              (rst),
    .dma_wr_valid     (dma_wr_valid),
    .dma_wr_req       (dma_wr_req),
    .dma_wr_ready     (dma_wr_ready),
    .dma_rd_valid     (dma_rd_valid),
    .dma_rd_addr      (dma_rd_addr),
    .dma_rd_ready     (dma_rd_ready),
    .dma_rd_resp_valid(dma_rd_resp_valid),
    .dma_rd_resp_data (dma_rd_resp_data),
    .dma_rd_resp_ready(dma_rd_resp_ready),
    .core_en          (core_en),
    .core_we          (core_we),
    .core_strb        (core_strb),
    .core_addr        (core_addr),
    .core_wdata       (core_wdata),
    .core_rd_valid    (core_rd_valid),
    .core_rd_data     (core_rd_data),
    .bc_valid         (bc_valid),
    .bc_msg           (bc_msg)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("Test failures found");
      $finish;
    end
  end

  //////////////////////////////////////////////////
  // Reference model

  function automatic void apply_write(input int unsigned addr, input logic [63:0] data,
                                     input logic [7:0] strb, input int unsigned nbytes);
    for (int i = 0; i < nbytes; i++) begin
      if (strb[i]) begin
        model[addr + i] = data[8*i +: 8];
      end
    end
  endfunction

  function automatic logic [63:0] expected_bytes(input int unsigned addr,
                                                 input int unsigned nbytes);
    logic [63:0] value;
    value = '0;
    for (int i = 0; i < nbytes; i++) begin
      value[8*i +: 8] = model[addr + i];
    end
    return value;
  endfunction

  task automatic report_mismatch(input string msg);
    errors++;
    $display("mismatch at %0t ns: %s", $time, msg);
  endtask

  task automatic check_idle_outputs(input string when_text);
    checks++;
    assert (dma_rd_resp_valid === 1'b0 && core_rd_valid === 1'b0
            && dma_wr_ready === 1'b1 && dma_rd_ready === 1'b1)
      else report_mismatch($sformatf("valid or ready outputs wrong %s", when_text));
  endtask

  //////////////////////////////////////////////////
  // Stimulus tasks that change inputs on the falling edge

  task automatic dma_write(input int unsigned addr, input logic [7:0] strb,
                           input logic [63:0] data);
    @(negedge clk);
    dma_wr_valid = 1'b1;
    dma_wr_req   = '{addr: mem_sys_pkg::dmem_addr_t'(addr), strb: strb, data: data};
    while (!dma_wr_ready) begin
      @(negedge clk);
    end
    apply_write(addr, data, strb, 8);
    @(posedge clk);
  endtask

  task automatic dma_read(input int unsigned addr);
    @(negedge clk);
    dma_rd_valid = 1'b1;
    dma_rd_addr  = mem_sys_pkg::dmem_addr_t'(addr);
    while (!dma_rd_ready) begin
      @(negedge clk);
    end
    // Every accepted write is already in the model, and the DUT drains them first
    exp_q.push_back(expected_bytes(addr, 8));
    @(posedge clk);
  endtask

  task automatic release_dma();
    @(negedge clk);
    dma_wr_valid = 1'b0;
    dma_rd_valid = 1'b0;
  endtask

  task automatic drain_responses();
    while (exp_q.size() != 0) begin
      @(negedge clk);
    end
    @(negedge clk);
  endtask

  task automatic core_write(input int unsigned addr, input logic [3:0] strb,
                            input logic [31:0] data);
    @(negedge clk);
    core_en    = 1'b1;
    core_we    = 1'b1;
    core_strb  = strb;
    core_addr  = mem_sys_pkg::dmem_addr_t'(addr);
    core_wdata = data;
    apply_write(addr, {32'h0, data}, {4'h0, strb}, 4);
    @(negedge clk);
    core_en = 1'b0;
    core_we = 1'b0;
  endtask

  task automatic core_read(input int unsigned addr);
    logic [63:0] exp_bytes;
    @(negedge clk);
    exp_bytes = expected_bytes(addr, 4);
    core_en   = 1'b1;
    core_we   = 1'b0;
    core_addr = mem_sys_pkg::dmem_addr_t'(addr);
    @(negedge clk);
    core_en = 1'b0;
    checks++;
    assert (core_rd_valid === 1'b1 && core_rd_data === exp_bytes[31:0])
      else report_mismatch($sformatf("core read of %h gave %h valid %b, expected %h",
                                     addr, core_rd_data, core_rd_valid, exp_bytes[31:0]));
    @(negedge clk);
    checks++;
    assert (core_rd_valid === 1'b0)
      else report_mismatch($sformatf("core_rd_valid high two cycles after read of %h", addr));
  endtask

  // Drives one message in the current cycle; the caller owns the timing
  task automatic drive_broadcast(input int unsigned idx, input logic [3:0] strb,
                                 input logic [31:0] data);
    int unsigned addr;
    addr     = int'(mem_sys_pkg::BC_START_ADDR) + 4 * idx;
    bc_valid = 1'b1;
    bc_msg   = '{word_addr: mem_sys_pkg::bc_word_addr_t'(idx), strb: strb, data: data};
    apply_write(addr, {32'h0, data}, {4'h0, strb}, 4);
    bc_lines.push_back(addr & ~32'h7);
  endtask

  task automatic send_broadcast(input int unsigned idx, input logic [3:0] strb,
                                input logic [31:0] data);
    @(negedge clk);
    drive_broadcast(idx, strb, data);
    @(negedge clk);
    bc_valid = 1'b0;
  endtask

  //////////////////////////////////////////////////
  // Response compare with random back-pressure

  initial begin
    logic [63:0] exp_line;
    dma_rd_resp_ready = 1'b0;
    forever begin
      @(negedge clk);
      dma_rd_resp_ready = resp_random ? 1'($urandom_range(0, 1)) : 1'b1;
      if (dma_rd_resp_valid && dma_rd_resp_ready) begin
        checks++;
        assert (exp_q.size() != 0) else begin
          errors++;
          $display("DMA response arrived with no read outstanding at %0t ns", $time);
        end
        if (exp_q.size() != 0) begin
          exp_line = exp_q.pop_front();
          assert (dma_rd_resp_data === exp_line)
            else report_mismatch($sformatf("DMA read data %h, expected %h",
                                           dma_rd_resp_data, exp_line));
        end
      end
    end
  end

  //////////////////////////////////////////////////
  // Test sequence

  initial begin
    int unsigned addr;
    int unsigned idx;
    void'($urandom(68));
    rst          = 1'b1;
    dma_wr_valid = 1'b0;
    dma_wr_req   = '0;
    dma_rd_valid = 1'b0;
    dma_rd_addr  = '0;
    core_en      = 1'b0;
    core_we      = 1'b0;
    core_strb    = '0;
    core_addr    = '0;
    core_wdata   = '0;
    bc_valid     = 1'b0;
    bc_msg       = '0;
    repeat (2) @(posedge clk);
    @(negedge clk);
    check_idle_outputs("during reset");
    rst = 1'b0;
    @(negedge clk);
    check_idle_outputs("after reset");

    // DMA lines with random strobes are read back while the response side stalls
    for (int i = 0; i < NUM_DMA; i++) begin
      addr = $urandom_range(0, 2047) << 3;
      dma_lines.push_back(addr);
      dma_write(addr, 8'($urandom), {$urandom, $urandom});
    end
    release_dma();
    resp_random = 1'b1;
    foreach (dma_lines[i]) begin
      dma_read(dma_lines[i]);
    end
    release_dma();
    drain_responses();
    resp_random = 1'b0;

    // Bits 2 and 3 walk through both lanes of both banks
    for (int i = 0; i < NUM_CORE; i++) begin
      addr = 'h4000 + ($urandom_range(0, 511) << 4) + ((i % 4) << 2);
      core_words.push_back(addr);
      core_write(addr, 4'($urandom), $urandom);
    end
    foreach (core_words[i]) begin
      core_read(core_words[i]);
    end

    // A full word goes first and a partial one is merged over it
    idx = $urandom_range(0, 255);
    send_broadcast(idx, 4'hF, $urandom);
    send_broadcast(idx, 4'($urandom), $urandom);
    repeat (3) @(negedge clk);
    core_read(int'(mem_sys_pkg::BC_START_ADDR) + 4 * idx);

    // Broadcast every cycle while a DMA write burst competes for port A
    dma_lines.delete();
    burst_done = 1'b0;
    fork
      begin
        for (int i = 0; i < NUM_BURST; i++) begin
          addr = $urandom_range(0, 2047) << 3;
          dma_lines.push_back(addr);
          dma_write(addr, 8'hFF, {$urandom, $urandom});
        end
        burst_done = 1'b1;
        release_dma();
      end
      begin
        @(negedge clk);
        while (!burst_done) begin
          drive_broadcast($urandom_range(0, 255), 4'($urandom), $urandom);
          @(negedge clk);
        end
        bc_valid = 1'b0;
      end
    join
    repeat (3) @(negedge clk);
    resp_random = 1'b1;
    foreach (dma_lines[i]) begin
      dma_read(dma_lines[i]);
    end
    foreach (bc_lines[i]) begin
      dma_read(bc_lines[i]);
    end
    release_dma();
    drain_responses();
    resp_random = 1'b0;

    repeat (4) @(negedge clk);
    errors += int'(dut.u_assert.failures);
    $display("Summary: %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

/* flist.f */
hdl/mem_sys_pkg.sv
hdl/req_fifo.sv
hdl/bc_msg_unpack.sv
hdl/core_lane_adapter.sv
hdl/dmem_port_arbiter.sv
hdl/dmem_bank.sv
hdl/dma_resp_path.sv
hdl/mem_sys_top.sv
verification/mem_sys_assert.sv
verification/mem_sys_tb.sv
